// ==== logic/eth_frame_pkg.sv ====
package eth_frame_pkg;

    // byte counts of the fixed frame parts.
    localparam int PREAMBLE_BYTES = 7;
    localparam int SFD_BYTES      = 1;
    localparam int HEADER_BYTES   = 42;
    localparam int FCS_BYTES      = 4;
    localparam int GAP_BYTES      = 12;

    localparam int IP_HDR_BYTES  = 20;
    localparam int UDP_HDR_BYTES = 8;

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;  // v4, five words.
    localparam logic [15:0] IP_FLAGS_DF    = 16'h4000;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [7:0]  IP_TTL         = 8'd64;

    localparam logic [31:0] CRC_RESIDUE_POLY = 32'hEDB88320;  // reflected 802.3 polynomial.

    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
        logic [15:0] port;
    } net_addr_t;

    // wire order, first byte in the top bits.
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_csum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_csum;
    } udp_frame_hdr_t;

endpackage

// ==== logic/tx_ctrl_pkg.sv ====
package tx_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        HEADER,
        PAYLOAD,
        FCS,
        GAP
    } frame_state_e;

    // source of the byte going to the output register.
    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_PREAMBLE,
        SRC_SFD,
        SRC_HEADER,
        SRC_PAYLOAD,
        SRC_FCS
    } byte_src_e;

    typedef struct packed {
        byte_src_e src;
        logic      load;      // new header in, crc back to all ones.
        logic      crc_en;
        logic      fifo_rd;
        logic      fcs_load;
    } phase_ctrl_t;

    function automatic int unsigned phase_length(frame_state_e state, int unsigned payload_len);
        case (state)
            PREAMBLE: return eth_frame_pkg::PREAMBLE_BYTES;
            SFD:      return eth_frame_pkg::SFD_BYTES;
            HEADER:   return eth_frame_pkg::HEADER_BYTES;
            PAYLOAD:  return payload_len;
            FCS:      return eth_frame_pkg::FCS_BYTES;
            GAP:      return eth_frame_pkg::GAP_BYTES;
            default:  return 1;  // idle is checked every cycle.
        endcase
    endfunction

endpackage

// ==== logic/phase_counter.sv ====
module phase_counter #(
    parameter int PAYLOAD_WIDTH = 11
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   restart_i,
    input  logic [PAYLOAD_WIDTH:0] len_i,
    output logic                   last_o
);

    localparam int CW = PAYLOAD_WIDTH + 1;

    logic [CW-1:0] cnt_q;

    // holds on the last byte until the sequencer moves on.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (restart_i) begin
            cnt_q <= '0;
        end else if (!last_o) begin
            cnt_q <= cnt_q + CW'(1);
        end
    end

    assign last_o = (cnt_q == len_i - CW'(1));

    assert property (@(posedge clk_i) disable iff (rst_i) len_i != '0 && cnt_q < len_i)
        else $error("phase_counter: zero length or count past the phase end");

endmodule

// ==== logic/frame_sequencer.sv ====
module frame_sequencer #(
    parameter int PAYLOAD_WIDTH = 11
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic [PAYLOAD_WIDTH:0]   fifo_count_i,
    input  logic [PAYLOAD_WIDTH-1:0] payload_len_i,
    input  logic                     last_i,
    output logic                     restart_o,
    output logic [PAYLOAD_WIDTH:0]   phase_len_o,
    output tx_ctrl_pkg::phase_ctrl_t ctrl_o
);

    import tx_ctrl_pkg::*;

    localparam int CW = PAYLOAD_WIDTH + 1;

    frame_state_e state_q;
    frame_state_e state_d;
    logic         start;

    assign start = (fifo_count_i >= {1'b0, payload_len_i});  // a whole payload is waiting.

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = PREAMBLE;
                end
            end
            PREAMBLE: state_d = last_i ? SFD : PREAMBLE;
            SFD:      state_d = last_i ? HEADER : SFD;
            HEADER:   state_d = last_i ? PAYLOAD : HEADER;
            PAYLOAD:  state_d = last_i ? FCS : PAYLOAD;
            FCS:      state_d = last_i ? GAP : FCS;
            GAP:      state_d = last_i ? IDLE : GAP;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign restart_o   = (state_d != state_q);
    assign phase_len_o = CW'(phase_length(state_q, int'(payload_len_i)));

    always_comb begin
        ctrl_o     = '0;
        ctrl_o.src = SRC_NONE;
        case (state_q)
            IDLE:     ctrl_o.load = start;
            PREAMBLE: ctrl_o.src = SRC_PREAMBLE;
            SFD:      ctrl_o.src = SRC_SFD;
            HEADER: begin
                ctrl_o.src     = SRC_HEADER;
                ctrl_o.crc_en  = 1'b1;
                ctrl_o.fifo_rd = last_i;  // fifo needs one cycle head start.
            end
            PAYLOAD: begin
                ctrl_o.src      = SRC_PAYLOAD;
                ctrl_o.crc_en   = 1'b1;
                ctrl_o.fifo_rd  = !last_i;
                ctrl_o.fcs_load = last_i;
            end
            FCS:      ctrl_o.src = SRC_FCS;
            default:  ctrl_o.src = SRC_NONE;
        endcase
    end

    // the whole payload is still waiting when its first byte is read.
    assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == HEADER && last_i) |-> fifo_count_i >= {1'b0, payload_len_i})
        else $error("frame_sequencer: payload phase began without a whole payload in the fifo");

endmodule

// ==== logic/payload_fifo.sv ====
module payload_fifo #(
    parameter int PAYLOAD_WIDTH = 11
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [7:0]             s_data_i,
    input  logic                   s_valid_i,
    output logic                   s_ready_o,
    input  logic                   rd_i,
    output logic [7:0]             rd_data_o,
    output logic [PAYLOAD_WIDTH:0] count_o
);

    localparam int DEPTH = 2 ** PAYLOAD_WIDTH;

    logic [7:0]               mem [DEPTH];
    logic [PAYLOAD_WIDTH-1:0] wr_ptr;
    logic [PAYLOAD_WIDTH-1:0] rd_ptr;
    logic                     wr;

    assign s_ready_o = !count_o[PAYLOAD_WIDTH];  // top bit only set when full.
    assign wr        = s_valid_i && s_ready_o;

    always_ff @(posedge clk_i) begin
        if (wr) begin
            mem[wr_ptr] <= s_data_i;
        end
        if (rd_i) begin
            rd_data_o <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd_i})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: count_o <= count_o;
            endcase
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i) rd_i |-> count_o != '0)
        else $error("payload_fifo: read while empty");

endmodule

// ==== logic/udp_header_builder.sv ====
module udp_header_builder #(
    parameter int PAYLOAD_WIDTH = 11
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  eth_frame_pkg::net_addr_t    local_i,
    input  eth_frame_pkg::net_addr_t    remote_i,
    input  logic [PAYLOAD_WIDTH-1:0]    payload_len_i,
    output eth_frame_pkg::udp_frame_hdr_t hdr_o
);

    import eth_frame_pkg::*;

    udp_frame_hdr_t hdr_d;
    logic [19:0]    sum;
    logic [16:0]    fold;
    logic [15:0]    fold2;

    always_comb begin
        hdr_d.dst_mac    = remote_i.mac;
        hdr_d.src_mac    = local_i.mac;
        hdr_d.ethertype  = ETHERTYPE_IPV4;
        hdr_d.ver_ihl    = IP_VER_IHL;
        hdr_d.tos        = 8'h00;
        hdr_d.total_len  = 16'(IP_HDR_BYTES + UDP_HDR_BYTES) + 16'(payload_len_i);
        hdr_d.ident      = 16'h0000;
        hdr_d.flags_frag = IP_FLAGS_DF;
        hdr_d.ttl        = IP_TTL;
        hdr_d.protocol   = IP_PROTO_UDP;
        hdr_d.src_ip     = local_i.ip;
        hdr_d.dst_ip     = remote_i.ip;
        hdr_d.src_port   = local_i.port;
        hdr_d.dst_port   = remote_i.port;
        hdr_d.udp_len    = 16'(UDP_HDR_BYTES) + 16'(payload_len_i);
        hdr_d.udp_csum   = 16'h0000;  // optional over ipv4.

        // ten header words, checksum word left out as zero.
        sum = 20'({hdr_d.ver_ihl, hdr_d.tos})
            + 20'(hdr_d.total_len)
            + 20'(hdr_d.ident)
            + 20'(hdr_d.flags_frag)
            + 20'({hdr_d.ttl, hdr_d.protocol})
            + 20'(hdr_d.src_ip[31:16])
            + 20'(hdr_d.src_ip[15:0])
            + 20'(hdr_d.dst_ip[31:16])
            + 20'(hdr_d.dst_ip[15:0]);

        // end-around carry, second fold catches the carry of the first.
        fold  = 17'(sum[15:0]) + 17'(sum[19:16]);
        fold2 = fold[15:0] + 16'(fold[16]);

        hdr_d.hdr_csum = ~fold2;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hdr_o <= '0;
        end else begin
            hdr_o <= hdr_d;
        end
    end

endmodule

// ==== logic/fcs_crc32.sv ====
module fcs_crc32 (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        clear_i,
    input  logic        en_i,
    input  logic [7:0]  data_i,
    output logic [31:0] fcs_o
);

    import eth_frame_pkg::*;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // bitwise reflected update, bit 0 of the byte goes first.
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data_i[i]) begin
                crc_next = (crc_next >> 1) ^ CRC_RESIDUE_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            crc_q <= '1;
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    // includes the byte accepted this cycle, so fcs is ready on the last payload byte.
    assign fcs_o = en_i ? ~crc_next : ~crc_q;

endmodule

// ==== logic/gmii_byte_mux.sv ====
module gmii_byte_mux (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  tx_ctrl_pkg::phase_ctrl_t      ctrl_i,
    input  eth_frame_pkg::udp_frame_hdr_t hdr_i,
    input  logic [7:0]                    fifo_data_i,
    input  logic [31:0]                   fcs_i,
    output logic [7:0]                    byte_o,
    output logic [7:0]                    gmii_txd_o,
    output logic                          gmii_tx_en_o
);

    import eth_frame_pkg::*;
    import tx_ctrl_pkg::*;

    localparam int HDR_W = $bits(udp_frame_hdr_t);
    localparam int PRE_W = (PREAMBLE_BYTES + SFD_BYTES) * 8;

    logic [HDR_W-1:0] hdr_sr;
    logic [PRE_W-1:0] pre_sr;  // preamble then sfd, top byte first.
    logic [31:0]      fcs_sr;

    always_ff @(posedge clk_i) begin
        if (ctrl_i.load) begin
            hdr_sr <= hdr_i;
            pre_sr <= {{PREAMBLE_BYTES{PREAMBLE_BYTE}}, SFD_BYTE};
        end
        if (ctrl_i.src == SRC_HEADER) begin
            hdr_sr <= hdr_sr << 8;
        end
        if (ctrl_i.src == SRC_PREAMBLE || ctrl_i.src == SRC_SFD) begin
            pre_sr <= pre_sr << 8;
        end
        if (ctrl_i.fcs_load) begin
            fcs_sr <= fcs_i;
        end else if (ctrl_i.src == SRC_FCS) begin
            fcs_sr <= fcs_sr >> 8;  // fcs goes out low byte first.
        end
    end

    always_comb begin
        case (ctrl_i.src)
            SRC_PREAMBLE, SRC_SFD: byte_o = pre_sr[PRE_W-1 -: 8];
            SRC_HEADER:            byte_o = hdr_sr[HDR_W-1 -: 8];
            SRC_PAYLOAD:           byte_o = fifo_data_i;
            SRC_FCS:               byte_o = fcs_sr[7:0];
            default:               byte_o = 8'h00;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gmii_tx_en_o <= 1'b0;
        end else begin
            gmii_tx_en_o <= (ctrl_i.src != SRC_NONE);
        end
        gmii_txd_o <= byte_o;
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        ctrl_i.load |-> ##(PREAMBLE_BYTES + SFD_BYTES + 1) ctrl_i.src == SRC_HEADER)
        else $error("gmii_byte_mux: header not aligned to the loaded frame");

    assert property (@(posedge clk_i) disable iff (rst_i)
        ctrl_i.fcs_load |=> (ctrl_i.src == SRC_FCS) [*FCS_BYTES])
        else $error("gmii_byte_mux: fcs latched without a following fcs phase");

endmodule

// ==== logic/udp_frame_tx.sv ====
module udp_frame_tx #(
    parameter int PAYLOAD_WIDTH = 11
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic [7:0]               s_data_i,
    input  logic                     s_valid_i,
    output logic                     s_ready_o,
    input  eth_frame_pkg::net_addr_t local_i,
    input  eth_frame_pkg::net_addr_t remote_i,
    input  logic [PAYLOAD_WIDTH-1:0] payload_len_i,
    output logic [7:0]               gmii_txd_o,
    output logic                     gmii_tx_en_o
);

    import eth_frame_pkg::*;
    import tx_ctrl_pkg::*;

    phase_ctrl_t            ctrl;
    udp_frame_hdr_t         hdr;
    logic [PAYLOAD_WIDTH:0] fifo_count;
    logic [PAYLOAD_WIDTH:0] phase_len;
    logic [7:0]             fifo_data;
    logic [7:0]             tx_byte;
    logic [31:0]            fcs;
    logic                   restart;
    logic                   last;

    frame_sequencer #(
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) u_seq (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fifo_count_i (fifo_count),
        .payload_len_i(payload_len_i),
        .last_i       (last),
        .restart_o    (restart),
        .phase_len_o  (phase_len),
        .ctrl_o       (ctrl)
    );

    phase_counter #(
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) u_cnt (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .restart_i(restart),
        .len_i    (phase_len),
        .last_o   (last)
    );

    payload_fifo #(
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) u_fifo (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .s_data_i (s_data_i),
        .s_valid_i(s_valid_i),
        .s_ready_o(s_ready_o),
        .rd_i     (ctrl.fifo_rd),
        .rd_data_o(fifo_data),
        .count_o  (fifo_count)
    );

    udp_header_builder #(
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) u_hdr (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .local_i      (local_i),
        .remote_i     (remote_i),
        .payload_len_i(payload_len_i),
        .hdr_o        (hdr)
    );

    fcs_crc32 u_crc (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .clear_i(ctrl.load),
        .en_i   (ctrl.crc_en),
        .data_i (tx_byte),
        .fcs_o  (fcs)
    );

    gmii_byte_mux u_mux (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ctrl_i      (ctrl),
        .hdr_i       (hdr),
        .fifo_data_i (fifo_data),
        .fcs_i       (fcs),
        .byte_o      (tx_byte),
        .gmii_txd_o  (gmii_txd_o),
        .gmii_tx_en_o(gmii_tx_en_o)
    );

endmodule

// ==== bench/udp_frame_tx_tb.sv ====
module udp_frame_tx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import eth_frame_pkg::*;

    localparam int          PAYLOAD_WIDTH   = 6;
    localparam int          FIFO_DEPTH      = 2 ** PAYLOAD_WIDTH;
    localparam int          NUM_FRAMES      = 40;
    localparam int          RESET_CYCLES    = 8;
    localparam int          WATCHDOG_CYCLES = NUM_FRAMES * (54 + 60 + 12 + 64) + RESET_CYCLES;
    localparam int unsigned SEED            = 32'h114e8d10;

    logic                     clk_i;
    logic                     rst_i;
    logic [7:0]               s_data_i;
    logic                     s_valid_i;
    logic                     s_ready_o;
    net_addr_t                local_i;
    net_addr_t                remote_i;
    logic [PAYLOAD_WIDTH-1:0] payload_len_i;
    logic [7:0]               gmii_txd_o;
    logic                     gmii_tx_en_o;

    int        len_tab [NUM_FRAMES];
    net_addr_t loc_tab [NUM_FRAMES];
    net_addr_t rem_tab [NUM_FRAMES];

    logic [7:0] byte_q [$];  // accepted bytes not yet sent.
    logic [7:0] rx_q [$];
    logic [7:0] exp_q [$];
    int         frames_seen  = 0;
    int         accepted_cnt = 0;
    int         payload_seen = 0;
    int         low_run      = 0;
    logic       in_frame     = 1'b0;
    logic       saw_full     = 1'b0;
    logic [1:0] acc_hist     = 2'b00;  // bytes accepted in the last two cycles.

    udp_frame_tx #(
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) dut0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .s_data_i     (s_data_i),
        .s_valid_i    (s_valid_i),
        .s_ready_o    (s_ready_o),
        .local_i      (local_i),
        .remote_i     (remote_i),
        .payload_len_i(payload_len_i),
        .gmii_txd_o   (gmii_txd_o),
        .gmii_tx_en_o (gmii_tx_en_o)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // most significant byte first, as on the wire.
    task automatic put_bytes(input logic [63:0] value, input int count);
        for (int b = count - 1; b >= 0; b--) begin
            exp_q.push_back(value[b*8 +: 8]);
        end
    endtask

    function automatic logic [15:0] ip_checksum(input logic [15:0] total_len,
                                                input logic [31:0] src, input logic [31:0] dst);
        logic [31:0] acc;
        acc = 32'h4500 + total_len + 32'h4000 + 32'h4011
            + src[31:16] + src[15:0] + dst[31:16] + dst[15:0];
        while (acc[31:16] != 0) begin
            acc = acc[15:0] + acc[31:16];
        end
        return ~acc[15:0];
    endfunction

    // msb-first form of the crc on bit-reversed bytes, reversed back at the end.
    function automatic logic [31:0] crc32_fcs(input int first, input int count);
        logic [31:0] crc;
        logic [31:0] rev;
        logic        fb;
        crc = '1;
        for (int i = first; i < first + count; i++) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[31] ^ exp_q[i][b];
                crc = {crc[30:0], 1'b0} ^ (fb ? 32'h04C11DB7 : 32'h0);
            end
        end
        for (int b = 0; b < 32; b++) begin
            rev[b] = crc[31-b];
        end
        return ~rev;
    endfunction

    function automatic string part_name(input int idx, input int n);
        if (idx < 7) return "preamble";
        if (idx < 8) return "sfd";
        if (idx < 50) return "header";
        if (idx < 50 + n) return "payload";
        return "fcs";
    endfunction

    task automatic check_frame(input int k);
        logic [15:0] ip_len;
        logic [31:0] fcs;
        int          n;
        n      = len_tab[k];
        ip_len = 16'(28 + n);
        assert (rx_q.size() == 54 + n)
            else fail_run($sformatf(
                "Fail gmii_tx_en_o high cycles in frame %0d: got %h expected %h",
                k, rx_q.size(), 54 + n));
        exp_q.delete();
        repeat (7) exp_q.push_back(8'h55);
        exp_q.push_back(8'hD5);
        put_bytes(rem_tab[k].mac, 6);
        put_bytes(loc_tab[k].mac, 6);
        put_bytes(16'h0800, 2);
        put_bytes(16'h4500, 2);
        put_bytes(ip_len, 2);
        put_bytes(16'h0000, 2);
        put_bytes(16'h4000, 2);  // don't fragment.
        put_bytes(16'h4011, 2);  // ttl 64, udp.
        put_bytes(ip_checksum(ip_len, loc_tab[k].ip, rem_tab[k].ip), 2);
        put_bytes(loc_tab[k].ip, 4);
        put_bytes(rem_tab[k].ip, 4);
        put_bytes(loc_tab[k].port, 2);
        put_bytes(rem_tab[k].port, 2);
        put_bytes(16'(8 + n), 2);
        put_bytes(16'h0000, 2);
        repeat (n) exp_q.push_back(byte_q.pop_front());
        fcs = crc32_fcs(8, 42 + n);
        for (int b = 0; b < 4; b++) begin
            exp_q.push_back(fcs[b*8 +: 8]);  // low byte first.
        end
        for (int i = 0; i < exp_q.size(); i++) begin
            assert (rx_q[i] === exp_q[i])
                else fail_run($sformatf(
                    "Fail gmii_txd_o frame %0d byte %0d (%s): got %h expected %h",
                    k, i, part_name(i, n), rx_q[i], exp_q[i]));
        end
    endtask

    task automatic set_config(input int k);
        local_i       = loc_tab[k];
        remote_i      = rem_tab[k];
        payload_len_i = PAYLOAD_WIDTH'(len_tab[k]);
    endtask

    task automatic push_stream(input int total);
        int idle;
        for (int i = 0; i < total; i++) begin
            idle = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 4) : 0;
            if (i % 500 == 250) begin
                idle = 200;  // long pause, frames wait for data.
            end
            if (idle != 0) begin
                s_valid_i = 1'b0;
                repeat (idle) @(posedge clk_i);
                #1;
            end
            s_data_i  = 8'($urandom);
            s_valid_i = 1'b1;
            @(negedge clk_i);
            while (!s_ready_o) @(negedge clk_i);
            @(posedge clk_i);
            #1;
        end
        s_valid_i = 1'b0;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // receiver and stream monitor, both sampled where signals are settled.
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (gmii_tx_en_o) begin
                if (!in_frame) begin
                    assert (frames_seen == 0 || low_run >= 12)
                        else fail_run($sformatf(
                            "Fail gmii_tx_en_o gap before frame %0d: got %h expected at least %h",
                            frames_seen, low_run, 12));
                    // bytes of the last two cycles had not reached the fifo count at the start.
                    assert (byte_q.size() - int'(acc_hist[0]) - int'(acc_hist[1])
                            >= len_tab[frames_seen])
                        else fail_run("a frame started before its whole payload was in the FIFO");
                    in_frame = 1'b1;
                    rx_q.delete();
                end
                rx_q.push_back(gmii_txd_o);
                if (rx_q.size() > 50 && rx_q.size() <= 50 + len_tab[frames_seen]) begin
                    payload_seen++;
                end
                assert (rx_q.size() <= 54 + len_tab[frames_seen])
                    else fail_run("gmii_tx_en_o stayed high past the end of the frame");
            end else begin
                if (in_frame) begin
                    check_frame(frames_seen);
                    frames_seen++;
                    in_frame = 1'b0;
                    low_run  = 0;
                end
                low_run++;
            end
            if (!s_ready_o) begin
                saw_full = 1'b1;
            end
            if (s_valid_i && s_ready_o) begin
                byte_q.push_back(s_data_i);
                accepted_cnt++;
            end
            acc_hist = {acc_hist[0], s_valid_i && s_ready_o};
        end
    end

    assert property (@(posedge clk_i) rst_i |=> !gmii_tx_en_o)
        else fail_run("gmii_tx_en_o was high during reset");

    // ready may only drop once the fifo can hold a full depth.
    assert property (@(posedge clk_i) disable iff (rst_i)
        !s_ready_o |-> (accepted_cnt - payload_seen) >= FIFO_DEPTH)
        else fail_run($sformatf("Fail s_ready_o: got %h expected %h", 1'b0, 1'b1));

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        fail_run("timeout: not all frames were sent in time");
    end

    initial begin
        int total_bytes;
        void'($urandom(SEED));
        total_bytes = 0;
        for (int k = 0; k < NUM_FRAMES; k++) begin
            len_tab[k]  = $urandom_range(18, 60);
            loc_tab[k]  = {$urandom, $urandom, $urandom};
            rem_tab[k]  = {$urandom, $urandom, $urandom};
            total_bytes = total_bytes + len_tab[k];
        end
        rst_i     = 1'b1;
        s_data_i  = 8'h00;
        s_valid_i = 1'b0;
        set_config(0);
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        assert (s_ready_o === 1'b1)
            else fail_run($sformatf("Fail s_ready_o after reset: got %h expected %h",
                                    s_ready_o, 1'b1));
        fork
            push_stream(total_bytes);
            begin
                for (int k = 1; k < NUM_FRAMES; k++) begin
                    wait (frames_seen == k);
                    @(posedge clk_i);
                    #1;
                    set_config(k);  // still inside the gap of the previous frame.
                end
            end
        join_none
        wait (frames_seen == NUM_FRAMES);
        if (byte_q.size() == 0 && saw_full) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run(byte_q.size() != 0 ? "payload bytes were left over after the last frame"
                                        : "the FIFO never became full during the run");
        end
    end

endmodule

// ==== vlog.f ====
logic/eth_frame_pkg.sv
logic/tx_ctrl_pkg.sv
logic/phase_counter.sv
logic/frame_sequencer.sv
logic/payload_fifo.sv
logic/udp_header_builder.sv
logic/fcs_crc32.sv
logic/gmii_byte_mux.sv
logic/udp_frame_tx.sv
bench/udp_frame_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= udp_frame_tx_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
